// ==== flist.f ====
+incdir+logic
logic/fetch_data_pkg.sv
logic/fetch_ctrl_pkg.sv
logic/channel_file.sv
logic/write_scoreboard.sv
logic/operand_issue.sv
logic/operand_fetch.sv
sim/operand_fetch_sva.sv
sim/operand_fetch_tb.sv

// ==== logic/channel_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module channel_file (
	input  wire                           clk,
	input  wire                           reset,

	input  wire                           write_enable,
	input  wire fetch_data_pkg::channel_t write_addr,
	input  wire fetch_data_pkg::sample_t  write_val,

	input  wire fetch_data_pkg::channel_t read_addr,
	output fetch_data_pkg::sample_t       read_val
);
	import fetch_data_pkg::*;

	sample_t channels [`N_CHANNELS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `N_CHANNELS; i++) begin
				channels[i] <= '0;
			end
		end else if (write_enable) begin
			channels[write_addr] <= write_val;
		end
	end

	assign read_val = channels[read_addr];  // combinational read, same cycle as the lookup

endmodule

`default_nettype wire

// ==== logic/fetch_ctrl_pkg.sv ====
`default_nettype none

`include "fetch_defs.svh"

package fetch_ctrl_pkg;

	typedef logic [`PENDING_BITS - 1 : 0] pending_t;

	typedef logic [`COMMIT_BITS - 1 : 0] commit_id_t;

	typedef logic [`OP_BITS - 1 : 0] op_t;

endpackage

`default_nettype wire

// ==== logic/fetch_data_pkg.sv ====
`default_nettype none

`include "fetch_defs.svh"

package fetch_data_pkg;

	typedef logic signed [`DATA_WIDTH - 1 : 0] sample_t;

	typedef logic [`CHANNEL_BITS - 1 : 0] channel_t;

	// codes 2 and 5 and up read as zero
	typedef enum logic [`CHANNEL_BITS - 1 : 0] {
		reg_zero_src   = 0,
		reg_one_src    = 1,
		half_scale_src = 3,
		full_scale_src = 4
	} reg_code_e;

	// one source field, read as a channel or a register code depending on src_reg
	typedef union packed {
		channel_t  channel;
		reg_code_e reg_code;
	} src_word_u;

endpackage

`default_nettype wire

// ==== logic/fetch_defs.svh ====
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// ########################################
// datapath and bookkeeping sizes
// ########################################

`define DATA_WIDTH   16
`define N_CHANNELS   16
`define CHANNEL_BITS 4
`define PENDING_BITS 4
`define COMMIT_BITS  9
`define OP_BITS      5

`endif

// ==== logic/operand_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_fetch (
	input  wire                            clk,
	input  wire                            reset,

	input  wire                            in_valid,
	output logic                           in_ready,

	input  wire fetch_ctrl_pkg::op_t       operation_in,
	input  wire fetch_data_pkg::channel_t  dest_in,
	input  wire                            writes_channel_in,
	input  wire fetch_data_pkg::src_word_u src_in,
	input  wire                            src_reg_in,
	input  wire                            arg_needed_in,
	input  wire fetch_data_pkg::sample_t   register_0_in,
	input  wire fetch_data_pkg::sample_t   register_1_in,

	input  wire                            channel_write_enable,
	input  wire fetch_data_pkg::channel_t  channel_write_addr,
	input  wire fetch_data_pkg::sample_t   channel_write_val,

	output logic                           out_valid,
	input  wire                            out_ready,
	output fetch_ctrl_pkg::op_t            operation_out,
	output fetch_data_pkg::channel_t       dest_out,
	output logic                           writes_channel_out,
	output fetch_data_pkg::sample_t        fetched_out,
	output fetch_ctrl_pkg::commit_id_t     commit_id_out
);
	import fetch_data_pkg::*;
	import fetch_ctrl_pkg::*;

	channel_t lookup_channel;
	sample_t read_val;
	pending_t pending_count;
	logic claim_valid;
	channel_t claim_channel;

	// storage and scoreboard both follow the writeback bus and the same lookup
	channel_file channel_file_i (
		.clk(clk),
		.reset(reset),
		.write_enable(channel_write_enable),
		.write_addr(channel_write_addr),
		.write_val(channel_write_val),
		.read_addr(lookup_channel),
		.read_val(read_val)
	);

	write_scoreboard write_scoreboard_i (
		.clk(clk),
		.reset(reset),
		.claim_valid(claim_valid),
		.claim_channel(claim_channel),
		.release_valid(channel_write_enable),
		.release_channel(channel_write_addr),
		.lookup_channel(lookup_channel),
		.pending_count(pending_count)
	);

	operand_issue operand_issue_i (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.operation_in(operation_in),
		.dest_in(dest_in),
		.writes_channel_in(writes_channel_in),
		.src_in(src_in),
		.src_reg_in(src_reg_in),
		.arg_needed_in(arg_needed_in),
		.register_0_in(register_0_in),
		.register_1_in(register_1_in),
		.read_val(read_val),
		.pending_count(pending_count),
		.channel_write_enable(channel_write_enable),
		.channel_write_addr(channel_write_addr),
		.channel_write_val(channel_write_val),
		.lookup_channel(lookup_channel),
		.claim_valid(claim_valid),
		.claim_channel(claim_channel),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.operation_out(operation_out),
		.dest_out(dest_out),
		.writes_channel_out(writes_channel_out),
		.fetched_out(fetched_out),
		.commit_id_out(commit_id_out)
	);

endmodule

`default_nettype wire

// ==== logic/operand_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module operand_issue (
	input  wire                            clk,
	input  wire                            reset,

	input  wire                            in_valid,
	output logic                           in_ready,

	input  wire fetch_ctrl_pkg::op_t       operation_in,
	input  wire fetch_data_pkg::channel_t  dest_in,
	input  wire                            writes_channel_in,

	input  wire fetch_data_pkg::src_word_u src_in,
	input  wire                            src_reg_in,
	input  wire                            arg_needed_in,

	input  wire fetch_data_pkg::sample_t   register_0_in,
	input  wire fetch_data_pkg::sample_t   register_1_in,

	input  wire fetch_data_pkg::sample_t   read_val,
	input  wire fetch_ctrl_pkg::pending_t  pending_count,

	input  wire                            channel_write_enable,
	input  wire fetch_data_pkg::channel_t  channel_write_addr,
	input  wire fetch_data_pkg::sample_t   channel_write_val,

	output fetch_data_pkg::channel_t       lookup_channel,
	output logic                           claim_valid,
	output fetch_data_pkg::channel_t       claim_channel,

	output logic                           out_valid,
	input  wire                            out_ready,
	output fetch_ctrl_pkg::op_t            operation_out,
	output fetch_data_pkg::channel_t       dest_out,
	output logic                           writes_channel_out,
	output fetch_data_pkg::sample_t        fetched_out,
	output fetch_ctrl_pkg::commit_id_t     commit_id_out
);
	import fetch_data_pkg::*;
	import fetch_ctrl_pkg::*;

	localparam sample_t half_scale = sample_t'(1) << (`DATA_WIDTH - 2);
	localparam sample_t full_scale = sample_t'(1) << (`DATA_WIDTH - 1);  // wraps to the minimum

	logic holding;
	op_t operation_held;
	channel_t dest_held;
	logic writes_channel_held;
	channel_t src_held;

	commit_id_t commit_count;

	sample_t reg_value;
	sample_t direct_value;
	sample_t held_value;

	op_t operation_live;
	logic writes_live;
	logic out_free;
	logic take_in;
	logic needs_wait;
	logic forward_hit;
	logic resolve;
	logic load_out;

	// ########################################
	// source decode
	// ########################################

	always_comb begin
		case (src_in.reg_code)
			reg_zero_src:   reg_value = register_0_in;
			reg_one_src:    reg_value = register_1_in;
			half_scale_src: reg_value = half_scale;
			full_scale_src: reg_value = full_scale;
			default:        reg_value = '0;
		endcase
	end

	always_comb begin
		if (!arg_needed_in)
			direct_value = '0;
		else if (src_reg_in)
			direct_value = reg_value;
		else
			direct_value = read_val;
	end

	// ########################################
	// stall and forward
	// ########################################

	assign out_free = ~out_valid | out_ready;
	assign in_ready = ~holding & out_free;
	assign take_in = in_valid & in_ready;

	assign lookup_channel = holding ? src_held : src_in.channel;
	assign needs_wait = arg_needed_in & ~src_reg_in & (pending_count != '0);

	// the last outstanding write lands this cycle, so take its value off the bus
	assign forward_hit = channel_write_enable & (channel_write_addr == src_held)
		& (pending_count == pending_t'(1));
	assign held_value = (pending_count == '0) ? read_val : channel_write_val;
	assign resolve = holding & out_free & ((pending_count == '0) | forward_hit);

	assign load_out = (take_in & ~needs_wait) | resolve;

	assign operation_live = holding ? operation_held : operation_in;
	assign writes_live = holding ? writes_channel_held : writes_channel_in;

	assign claim_valid = load_out & writes_live;
	assign claim_channel = holding ? dest_held : dest_in;

	always_ff @(posedge clk) begin
		if (reset) begin
			holding <= 1'b0;
			out_valid <= 1'b0;
			commit_count <= '0;
		end else begin
			if (take_in & needs_wait)
				holding <= 1'b1;
			else if (resolve)
				holding <= 1'b0;

			if (load_out)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0;

			if (claim_valid)
				commit_count <= commit_count + commit_id_t'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (take_in & needs_wait) begin
			operation_held <= operation_in;
			dest_held <= dest_in;
			writes_channel_held <= writes_channel_in;
			src_held <= src_in.channel;
		end

		if (load_out) begin
			operation_out <= operation_live;
			dest_out <= claim_channel;
			writes_channel_out <= writes_live;
			fetched_out <= holding ? held_value : direct_value;
			commit_id_out <= commit_count;  // only advances past channel writers
		end
	end

endmodule

`default_nettype wire

// ==== logic/write_scoreboard.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module write_scoreboard (
	input  wire                           clk,
	input  wire                           reset,

	input  wire                           claim_valid,
	input  wire fetch_data_pkg::channel_t claim_channel,

	input  wire                           release_valid,
	input  wire fetch_data_pkg::channel_t release_channel,

	input  wire fetch_data_pkg::channel_t lookup_channel,
	output fetch_ctrl_pkg::pending_t      pending_count
);
	import fetch_ctrl_pkg::*;

	pending_t counts [`N_CHANNELS];

	logic [`N_CHANNELS - 1 : 0] claim_hit;
	logic [`N_CHANNELS - 1 : 0] release_hit;

	always_comb begin
		claim_hit = '0;
		release_hit = '0;
		if (claim_valid)
			claim_hit[claim_channel] = 1'b1;
		if (release_valid)
			release_hit[release_channel] = 1'b1;
	end

	// ########################################
	// one counter per channel
	// ########################################

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `N_CHANNELS; i++) begin
				counts[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `N_CHANNELS; i++) begin
				case ({claim_hit[i], release_hit[i]})
					2'b10: counts[i] <= counts[i] + pending_t'(1);
					2'b01: begin
						if (counts[i] != '0)  // a stray release at zero is dropped
							counts[i] <= counts[i] - pending_t'(1);
					end
					default: counts[i] <= counts[i];  // idle, or claim and release cancel
				endcase
			end
		end
	end

	assign pending_count = counts[lookup_channel];

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module operand_fetch_tb \
	-f flist.f \
	--Mdir obj_dir -o operand_fetch_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/operand_fetch_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation run failed with status $status"
	exit "$status"
fi
exit 0

// ==== sim/operand_fetch_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_fetch_sva (
	input  wire                             clk,
	input  wire                             reset,
	input  wire                             in_ready,
	input  wire                             out_valid,
	input  wire                             out_ready,
	input  wire fetch_ctrl_pkg::op_t        operation_out,
	input  wire fetch_data_pkg::channel_t   dest_out,
	input  wire                             writes_channel_out,
	input  wire fetch_data_pkg::sample_t    fetched_out,
	input  wire fetch_ctrl_pkg::commit_id_t commit_id_out
);

	// ########################################
	// output protocol
	// ########################################

	output_held: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(operation_out) && $stable(dest_out)
			&& $stable(writes_channel_out) && $stable(fetched_out) && $stable(commit_id_out))
		else $error("output changed while the sink was stalling");

	input_blocked: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |-> !in_ready)
		else $error("in_ready was high while the output was stalled");

	idle_after_reset: assert property (@(posedge clk) reset |=> !out_valid)
		else $error("out_valid was high right after reset");

endmodule

`default_nettype wire

// ==== sim/operand_fetch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module operand_fetch_tb;
	import fetch_data_pkg::*;
	import fetch_ctrl_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int N_ROWS = 40;
	localparam int CYCLES_PER_ROW = 40;
	localparam int TIMEOUT_MARGIN = 200;
	localparam int DRAIN_CYCLES = 20;

	typedef struct packed {
		op_t op;
		channel_t dest;
		logic writes;
		channel_t src;
		logic src_reg;
		logic arg_needed;
		sample_t reg0;
		sample_t reg1;
		sample_t wb_val;
		sample_t fetched;
		commit_id_t commit_id;
	} row_t;

	logic clk;
	logic reset;
	logic in_valid;
	logic in_ready;
	op_t operation_in;
	channel_t dest_in;
	logic writes_channel_in;
	src_word_u src_in;
	logic src_reg_in;
	logic arg_needed_in;
	sample_t register_0_in;
	sample_t register_1_in;
	logic channel_write_enable;
	channel_t channel_write_addr;
	sample_t channel_write_val;
	logic out_valid;
	logic out_ready;
	op_t operation_out;
	channel_t dest_out;
	logic writes_channel_out;
	sample_t fetched_out;
	commit_id_t commit_id_out;

	row_t rows [N_ROWS];
	int n_rows_built = 0;
	int out_count = 0;
	int wb_delay = 0;
	int wb_queue [$];

	operand_fetch operand_fetch_i (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.operation_in(operation_in),
		.dest_in(dest_in),
		.writes_channel_in(writes_channel_in),
		.src_in(src_in),
		.src_reg_in(src_reg_in),
		.arg_needed_in(arg_needed_in),
		.register_0_in(register_0_in),
		.register_1_in(register_1_in),
		.channel_write_enable(channel_write_enable),
		.channel_write_addr(channel_write_addr),
		.channel_write_val(channel_write_val),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.operation_out(operation_out),
		.dest_out(dest_out),
		.writes_channel_out(writes_channel_out),
		.fetched_out(fetched_out),
		.commit_id_out(commit_id_out)
	);

	bind operand_fetch operand_fetch_sva operand_fetch_sva_i (
		.clk(clk),
		.reset(reset),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.operation_out(operation_out),
		.dest_out(dest_out),
		.writes_channel_out(writes_channel_out),
		.fetched_out(fetched_out),
		.commit_id_out(commit_id_out)
	);

	task automatic compare_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Error at %0t: %s is 0x%0h, expected 0x%0h",
				$time, name, actual, expected);
			$display("Finished with errors");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	// ########################################
	// stimulus table and shadow model
	// ########################################

	task automatic add_row(input op_t op, input channel_t dest, input logic writes,
		input channel_t src, input logic src_reg, input logic arg_needed,
		input sample_t reg0, input sample_t reg1, input sample_t wb_val);
		rows[n_rows_built] = '{op, dest, writes, src, src_reg, arg_needed,
			reg0, reg1, wb_val, 16'sd0, 9'd0};
		n_rows_built++;
	endtask

	task automatic add_random_row();
		logic src_reg;
		src_reg = ($urandom % 10) < 4;
		add_row(op_t'($urandom), channel_t'($urandom % 8), ($urandom % 10) < 6,
			src_reg ? channel_t'($urandom % 6) : channel_t'($urandom % 8), src_reg,
			($urandom % 10) < 9, sample_t'($urandom), sample_t'($urandom),
			sample_t'($urandom));
	endtask

	function automatic sample_t reg_source(input row_t r);
		case (r.src)
			4'd0: return r.reg0;
			4'd1: return r.reg1;
			4'd3: return 16'sh4000;  // half scale
			4'd4: return 16'sh8000;  // full scale is the most negative word
			default: return 16'sd0;
		endcase
	endfunction

	task automatic fill_expected();
		sample_t shadow [`N_CHANNELS];
		int writers;
		writers = 0;
		foreach (shadow[c])
			shadow[c] = '0;
		for (int i = 0; i < N_ROWS; i++) begin
			if (!rows[i].arg_needed)
				rows[i].fetched = '0;
			else if (rows[i].src_reg)
				rows[i].fetched = reg_source(rows[i]);
			else
				rows[i].fetched = shadow[rows[i].src];  // sees every earlier write
			rows[i].commit_id = commit_id_t'(writers);
			if (rows[i].writes) begin
				shadow[rows[i].dest] = rows[i].wb_val;
				writers++;
			end
		end
	endtask

	task automatic build_table();
		add_row(5'd1, 4'd0, 1'b0, 4'd0, 1'b1, 1'b0, 16'sh1357, 16'sh7ace, 16'sh0);
		add_row(5'd2, 4'd1, 1'b0, 4'd0, 1'b1, 1'b1, 16'sh1357, 16'sh7ace, 16'sh0);
		add_row(5'd3, 4'd2, 1'b0, 4'd1, 1'b1, 1'b1, 16'sh1357, 16'sh7ace, 16'sh0);
		add_row(5'd4, 4'd3, 1'b0, 4'd3, 1'b1, 1'b1, 16'sh1357, 16'sh7ace, 16'sh0);
		add_row(5'd5, 4'd4, 1'b0, 4'd4, 1'b1, 1'b1, 16'sh1357, 16'sh7ace, 16'sh0);
		add_row(5'd6, 4'd0, 1'b0, 4'd2, 1'b1, 1'b1, 16'sh1357, 16'sh7ace, 16'sh0);
		add_row(5'd7, 4'd0, 1'b0, 4'd9, 1'b1, 1'b1, 16'sh1357, 16'sh7ace, 16'sh0);
		add_row(5'd8, 4'd0, 1'b0, 4'd5, 1'b0, 1'b1, 16'sh1357, 16'sh7ace, 16'sh0);
		add_row(5'd9, 4'd5, 1'b1, 4'd1, 1'b1, 1'b1, 16'sh1357, 16'sh7ace, 16'sh1234);
		add_row(5'd10, 4'd0, 1'b0, 4'd5, 1'b0, 1'b1, 16'sh1357, 16'sh7ace, 16'sh0);
		add_row(5'd11, 4'd6, 1'b1, 4'd0, 1'b0, 1'b0, 16'sh1357, 16'sh7ace, 16'sh0aaa);
		add_row(5'd12, 4'd6, 1'b1, 4'd6, 1'b0, 1'b1, 16'sh1357, 16'sh7ace, 16'sh0bbb);
		add_row(5'd13, 4'd7, 1'b0, 4'd6, 1'b0, 1'b1, 16'sh1357, 16'sh7ace, 16'sh0);
		add_row(5'd14, 4'd7, 1'b0, 4'd9, 1'b0, 1'b0, 16'sh1357, 16'sh7ace, 16'sh0);
		while (n_rows_built < N_ROWS)
			add_random_row();
		fill_expected();
	endtask

	task automatic compare_output(input int k);
		compare_value("operation_out", 32'(operation_out), 32'(rows[k].op));
		compare_value("dest_out", 32'(dest_out), 32'(rows[k].dest));
		compare_value("writes_channel_out", 32'(writes_channel_out), 32'(rows[k].writes));
		compare_value("fetched_out", 32'($unsigned(fetched_out)),
			32'($unsigned(rows[k].fetched)));
		if (rows[k].writes)
			compare_value("commit_id_out", 32'(commit_id_out), 32'(rows[k].commit_id));
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#((N_ROWS * CYCLES_PER_ROW + TIMEOUT_MARGIN) * CLK_PERIOD);
		$display("Timeout: only %0d of %0d outputs arrived in time", out_count, N_ROWS);
		$display("Finished with errors");
		$fatal(1, "watchdog expired");
	end

	// ########################################
	// sink, output monitor and writeback model
	// ########################################

	initial begin
		int wb_index;
		int accept_count;
		logic direct_check;
		accept_count = 0;
		direct_check = 1'b0;
		out_ready <= 1'b0;
		channel_write_enable <= 1'b0;
		channel_write_addr <= '0;
		channel_write_val <= '0;
		forever begin
			@(posedge clk);
			channel_write_enable <= 1'b0;
			if (!reset) begin
				if (direct_check)  // register and constant sources never wait
					compare_value("out_valid", 32'(out_valid), 32'(1));
				direct_check = 1'b0;
				if (in_valid && in_ready) begin
					if (accept_count < N_ROWS)
						direct_check = rows[accept_count].src_reg
							|| !rows[accept_count].arg_needed;
					accept_count++;
				end
				if (out_valid && out_ready) begin
					if (out_count >= N_ROWS) begin
						$display("Error: an output came out after all %0d rows", N_ROWS);
						$display("Finished with errors");
						$fatal(1, "extra output");
					end else begin
						compare_output(out_count);
						if (rows[out_count].writes)
							wb_queue.push_back(out_count);  // writes land in program order
						out_count++;
					end
				end
				if (wb_queue.size() != 0) begin
					if (wb_delay == 0) begin
						wb_index = wb_queue.pop_front();
						channel_write_enable <= 1'b1;
						channel_write_addr <= rows[wb_index].dest;
						channel_write_val <= rows[wb_index].wb_val;
						wb_delay = $urandom % 6;
					end else begin
						wb_delay--;
					end
				end
				out_ready <= ($urandom % 10) >= 3;
			end
		end
	end

	initial begin
		void'($urandom(49));
		reset <= 1'b1;
		in_valid <= 1'b0;
		operation_in <= '0;
		dest_in <= '0;
		writes_channel_in <= 1'b0;
		src_in <= '0;
		src_reg_in <= 1'b0;
		arg_needed_in <= 1'b0;
		register_0_in <= '0;
		register_1_in <= '0;
		build_table();
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		for (int i = 0; i < N_ROWS; i++) begin
			in_valid <= 1'b1;
			operation_in <= rows[i].op;
			dest_in <= rows[i].dest;
			writes_channel_in <= rows[i].writes;
			src_in <= rows[i].src;
			src_reg_in <= rows[i].src_reg;
			arg_needed_in <= rows[i].arg_needed;
			register_0_in <= rows[i].reg0;
			register_1_in <= rows[i].reg1;
			do @(posedge clk); while (!in_ready);
		end
		in_valid <= 1'b0;
		wait (out_count == N_ROWS);
		while (wb_queue.size() != 0)
			@(posedge clk);
		repeat (DRAIN_CYCLES) @(posedge clk);  // window for a stray extra output
		if (in_ready && !out_valid) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			$display("Error: the DUT did not return to idle after the last output");
			$display("Finished with errors");
			$fatal(1, "DUT not idle at the end");
		end
	end

endmodule

`default_nettype wire
